/* design/isa_pkg.sv */
package isa_pkg;

	localparam int word_w = 16;
	localparam int reg_count = 4;

	typedef logic [word_w-1:0] word_t;
	typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

	// Instruction word fields
	localparam int opcode_hi = 15;
	localparam int opcode_lo = 12;
	localparam int rs_hi = 11;
	localparam int rs_lo = 10;
	localparam int rt_hi = 9;
	localparam int rt_lo = 8;
	localparam int rd_hi = 7;
	localparam int rd_lo = 6;
	localparam int func_hi = 5;
	localparam int func_lo = 0;
	localparam int imm_hi = 7;
	localparam int imm_lo = 0;
	localparam int target_hi = 11;
	localparam int target_lo = 0;

	typedef enum logic [3:0] {
		op_bne   = 4'd0,
		op_beq   = 4'd1,
		op_adi   = 4'd4,
		op_lhi   = 4'd6,
		op_lwd   = 4'd7,
		op_swd   = 4'd8,
		op_jmp   = 4'd9,
		op_jal   = 4'd10,
		op_rtype = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_jpr = 6'd25,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} func_t;

	// JAL return address goes here
	localparam reg_idx_t link_reg = 2'd2;

endpackage

/* design/ctrl_pkg.sv */
package ctrl_pkg;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_memory,
		st_writeback,
		st_halted
	} state_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_pass_b
	} alu_op_t;

	typedef enum logic {
		src_a_pc,
		src_a_reg
	} src_a_t;

	typedef enum logic [2:0] {
		src_b_reg,
		src_b_one,
		src_b_simm,
		src_b_uimm,
		src_b_target
	} src_b_t;

	typedef enum logic [1:0] {
		wb_alu_out,
		wb_mdr,
		wb_pc
	} wb_t;

	typedef enum logic [1:0] {
		dest_rd,
		dest_rt,
		dest_link
	} dest_t;

	typedef enum logic [1:0] {
		pc_src_alu,
		pc_src_alu_out,
		pc_src_reg_a
	} pc_src_t;

	// All-zero value means no action
	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic addr_from_alu_out;
		logic ir_write;
		logic mdr_write;
		logic pc_write;
		logic pc_write_cond;
		logic branch_on_ne;
		logic reg_write;
		dest_t dest;
		wb_t wb;
		src_a_t src_a;
		src_b_t src_b;
		alu_op_t alu_op;
		pc_src_t pc_src;
		logic out_write;
	} ctrl_t;

endpackage

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
	input isa_pkg::word_t a,
	input isa_pkg::word_t b,
	input ctrl_pkg::alu_op_t op,
	output isa_pkg::word_t result,
	output logic zero
);

	always_comb begin
		case (op)
			ctrl_pkg::alu_add: begin
				result = a + b;
			end
			ctrl_pkg::alu_sub: begin
				result = a - b;
			end
			ctrl_pkg::alu_and: begin
				result = a & b;
			end
			ctrl_pkg::alu_or: begin
				result = a | b;
			end
			ctrl_pkg::alu_pass_b: begin
				result = b;
			end
			default: begin
				result = b;
			end
		endcase
	end

	// Compare on the raw inputs so branches need not care about op
	assign zero = (a == b);

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input logic clk,
	input logic reset_n,
	input isa_pkg::reg_idx_t read_idx_1,
	input isa_pkg::reg_idx_t read_idx_2,
	input isa_pkg::reg_idx_t write_idx,
	input isa_pkg::word_t write_data,
	input logic write_en,
	output isa_pkg::word_t read_data_1,
	output isa_pkg::word_t read_data_2
);

	isa_pkg::word_t regs [isa_pkg::reg_count];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			regs <= '{default: '0};
		end else if (write_en) begin
			regs[write_idx] <= write_data;
		end
	end

	assign read_data_1 = regs[read_idx_1];
	assign read_data_2 = regs[read_idx_2];

endmodule

/* design/datapath.sv */
`timescale 1ns/1ps

module datapath (
	input logic clk,
	input logic reset_n,
	input ctrl_pkg::ctrl_t ctrl,
	inout wire isa_pkg::word_t data,
	output isa_pkg::word_t address,
	output isa_pkg::word_t inst,
	output logic zero,
	output isa_pkg::word_t output_port
);

	isa_pkg::word_t pc;
	isa_pkg::word_t mdr;
	isa_pkg::word_t a_reg;
	isa_pkg::word_t b_reg;
	isa_pkg::word_t alu_out;
	isa_pkg::word_t rf_data_1;
	isa_pkg::word_t rf_data_2;
	isa_pkg::word_t alu_a;
	isa_pkg::word_t alu_b;
	isa_pkg::word_t alu_result;
	isa_pkg::word_t simm;
	isa_pkg::word_t uimm;
	isa_pkg::word_t target;
	isa_pkg::word_t wb_data;
	isa_pkg::word_t pc_next;
	isa_pkg::reg_idx_t rs;
	isa_pkg::reg_idx_t rt;
	isa_pkg::reg_idx_t rd;
	isa_pkg::reg_idx_t dest_idx;
	logic pc_en;

	assign rs = inst[isa_pkg::rs_hi:isa_pkg::rs_lo];
	assign rt = inst[isa_pkg::rt_hi:isa_pkg::rt_lo];
	assign rd = inst[isa_pkg::rd_hi:isa_pkg::rd_lo];

	assign simm = isa_pkg::word_t'(signed'(inst[isa_pkg::imm_hi:isa_pkg::imm_lo]));
	assign uimm = {inst[isa_pkg::imm_hi:isa_pkg::imm_lo], 8'h00};
	// Page bits come from the already incremented pc
	assign target = {pc[isa_pkg::word_w-1:isa_pkg::target_hi+1],
		inst[isa_pkg::target_hi:isa_pkg::target_lo]};

	always_comb begin
		case (ctrl.src_a)
			ctrl_pkg::src_a_pc: alu_a = pc;
			default: alu_a = a_reg;
		endcase
		case (ctrl.src_b)
			ctrl_pkg::src_b_one: alu_b = isa_pkg::word_t'(1);
			ctrl_pkg::src_b_simm: alu_b = simm;
			ctrl_pkg::src_b_uimm: alu_b = uimm;
			ctrl_pkg::src_b_target: alu_b = target;
			default: alu_b = b_reg;
		endcase
		case (ctrl.wb)
			ctrl_pkg::wb_mdr: wb_data = mdr;
			ctrl_pkg::wb_pc: wb_data = pc;
			default: wb_data = alu_out;
		endcase
		case (ctrl.dest)
			ctrl_pkg::dest_rt: dest_idx = rt;
			ctrl_pkg::dest_link: dest_idx = isa_pkg::link_reg;
			default: dest_idx = rd;
		endcase
		// JPR takes rs straight from the register file during decode
		case (ctrl.pc_src)
			ctrl_pkg::pc_src_alu_out: pc_next = alu_out;
			ctrl_pkg::pc_src_reg_a: pc_next = rf_data_1;
			default: pc_next = alu_result;
		endcase
	end

	assign pc_en = ctrl.pc_write || (ctrl.pc_write_cond && (zero != ctrl.branch_on_ne));

	assign address = ctrl.addr_from_alu_out ? alu_out : pc;
	assign data = ctrl.mem_write ? b_reg : 'z;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			output_port <= '0;
		end else begin
			if (pc_en) begin
				pc <= pc_next;
			end
			if (ctrl.out_write) begin
				output_port <= rf_data_1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.ir_write) begin
			inst <= data;
		end
		if (ctrl.mdr_write) begin
			mdr <= data;
		end
		a_reg <= rf_data_1;
		b_reg <= rf_data_2;
		alu_out <= alu_result;
	end

	register_file register_file_inst (
		.clk(clk),
		.reset_n(reset_n),
		.read_idx_1(rs),
		.read_idx_2(rt),
		.write_idx(dest_idx),
		.write_data(wb_data),
		.write_en(ctrl.reg_write),
		.read_data_1(rf_data_1),
		.read_data_2(rf_data_2)
	);

	alu alu_inst (
		.a(alu_a),
		.b(alu_b),
		.op(ctrl.alu_op),
		.result(alu_result),
		.zero(zero)
	);

endmodule

/* design/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm (
	input logic clk,
	input logic reset_n,
	input isa_pkg::word_t inst,
	output ctrl_pkg::ctrl_t ctrl,
	output isa_pkg::word_t num_inst,
	output logic is_halted
);

	ctrl_pkg::state_t state;
	ctrl_pkg::state_t state_next;
	ctrl_pkg::ctrl_t ctrl_raw;
	isa_pkg::opcode_t opcode;
	isa_pkg::func_t func;
	logic inst_done;

	assign opcode = isa_pkg::opcode_t'(inst[isa_pkg::opcode_hi:isa_pkg::opcode_lo]);
	assign func = isa_pkg::func_t'(inst[isa_pkg::func_hi:isa_pkg::func_lo]);

	always_comb begin
		ctrl_raw = '0;
		state_next = state;
		inst_done = 1'b0;
		case (state)
			ctrl_pkg::st_fetch: begin
				ctrl_raw.mem_read = 1'b1;
				ctrl_raw.ir_write = 1'b1;
				ctrl_raw.src_a = ctrl_pkg::src_a_pc;
				ctrl_raw.src_b = ctrl_pkg::src_b_one;
				ctrl_raw.pc_src = ctrl_pkg::pc_src_alu;
				ctrl_raw.pc_write = 1'b1;
				state_next = ctrl_pkg::st_decode;
			end
			ctrl_pkg::st_decode: begin
				// Branch target lands in the ALU output register
				ctrl_raw.src_a = ctrl_pkg::src_a_pc;
				ctrl_raw.src_b = ctrl_pkg::src_b_simm;
				state_next = ctrl_pkg::st_fetch;
				inst_done = 1'b1;
				case (opcode)
					isa_pkg::op_jmp, isa_pkg::op_jal: begin
						ctrl_raw.src_b = ctrl_pkg::src_b_target;
						ctrl_raw.alu_op = ctrl_pkg::alu_pass_b;
						ctrl_raw.pc_src = ctrl_pkg::pc_src_alu;
						ctrl_raw.pc_write = 1'b1;
						ctrl_raw.reg_write = (opcode == isa_pkg::op_jal);
						ctrl_raw.dest = ctrl_pkg::dest_link;
						ctrl_raw.wb = ctrl_pkg::wb_pc;
					end
					isa_pkg::op_adi, isa_pkg::op_lhi, isa_pkg::op_lwd, isa_pkg::op_swd,
					isa_pkg::op_bne, isa_pkg::op_beq: begin
						state_next = ctrl_pkg::st_execute;
						inst_done = 1'b0;
					end
					isa_pkg::op_rtype: begin
						case (func)
							isa_pkg::fn_add, isa_pkg::fn_sub, isa_pkg::fn_and,
							isa_pkg::fn_orr: begin
								state_next = ctrl_pkg::st_execute;
								inst_done = 1'b0;
							end
							isa_pkg::fn_jpr: begin
								ctrl_raw.pc_src = ctrl_pkg::pc_src_reg_a;
								ctrl_raw.pc_write = 1'b1;
							end
							isa_pkg::fn_wwd: begin
								ctrl_raw.out_write = 1'b1;
							end
							isa_pkg::fn_hlt: begin
								state_next = ctrl_pkg::st_halted;
								inst_done = 1'b0;
							end
							default: ;
						endcase
					end
					// Unsupported opcodes retire as no-ops
					default: ;
				endcase
			end
			ctrl_pkg::st_execute: begin
				ctrl_raw.src_a = ctrl_pkg::src_a_reg;
				ctrl_raw.src_b = ctrl_pkg::src_b_simm;
				state_next = ctrl_pkg::st_writeback;
				case (opcode)
					isa_pkg::op_rtype: begin
						ctrl_raw.src_b = ctrl_pkg::src_b_reg;
						case (func)
							isa_pkg::fn_sub: ctrl_raw.alu_op = ctrl_pkg::alu_sub;
							isa_pkg::fn_and: ctrl_raw.alu_op = ctrl_pkg::alu_and;
							isa_pkg::fn_orr: ctrl_raw.alu_op = ctrl_pkg::alu_or;
							default: ctrl_raw.alu_op = ctrl_pkg::alu_add;
						endcase
					end
					isa_pkg::op_lhi: begin
						ctrl_raw.src_b = ctrl_pkg::src_b_uimm;
						ctrl_raw.alu_op = ctrl_pkg::alu_pass_b;
					end
					isa_pkg::op_lwd, isa_pkg::op_swd: begin
						state_next = ctrl_pkg::st_memory;
					end
					isa_pkg::op_bne, isa_pkg::op_beq: begin
						ctrl_raw.src_b = ctrl_pkg::src_b_reg;
						ctrl_raw.alu_op = ctrl_pkg::alu_sub;
						ctrl_raw.pc_src = ctrl_pkg::pc_src_alu_out;
						ctrl_raw.pc_write_cond = 1'b1;
						ctrl_raw.branch_on_ne = (opcode == isa_pkg::op_bne);
						state_next = ctrl_pkg::st_fetch;
						inst_done = 1'b1;
					end
					default: ;
				endcase
			end
			ctrl_pkg::st_memory: begin
				ctrl_raw.addr_from_alu_out = 1'b1;
				if (opcode == isa_pkg::op_lwd) begin
					ctrl_raw.mem_read = 1'b1;
					ctrl_raw.mdr_write = 1'b1;
					state_next = ctrl_pkg::st_writeback;
				end else begin
					ctrl_raw.mem_write = 1'b1;
					state_next = ctrl_pkg::st_fetch;
					inst_done = 1'b1;
				end
			end
			ctrl_pkg::st_writeback: begin
				ctrl_raw.reg_write = 1'b1;
				ctrl_raw.dest = (opcode == isa_pkg::op_rtype) ? ctrl_pkg::dest_rd : ctrl_pkg::dest_rt;
				ctrl_raw.wb = (opcode == isa_pkg::op_lwd) ? ctrl_pkg::wb_mdr : ctrl_pkg::wb_alu_out;
				state_next = ctrl_pkg::st_fetch;
				inst_done = 1'b1;
			end
			// Halted: nothing moves until reset
			default: ;
		endcase
	end

	// Bus strobes must stay low while reset is held
	assign ctrl = reset_n ? ctrl_raw : '0;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ctrl_pkg::st_fetch;
			num_inst <= '0;
		end else begin
			state <= state_next;
			if (inst_done) begin
				num_inst <= num_inst + isa_pkg::word_t'(1);
			end
		end
	end

	assign is_halted = (state == ctrl_pkg::st_halted);

endmodule

/* design/cpu.sv */
`timescale 1ns/1ps

module cpu (
	input logic clk,
	input logic reset_n,
	output logic read_m,
	output logic write_m,
	output isa_pkg::word_t address,
	inout wire isa_pkg::word_t data,
	output isa_pkg::word_t num_inst,
	output isa_pkg::word_t output_port,
	output logic is_halted
);

	ctrl_pkg::ctrl_t ctrl;
	isa_pkg::word_t inst;

	assign read_m = ctrl.mem_read;
	assign write_m = ctrl.mem_write;

	control_fsm control_fsm_inst (
		.clk(clk),
		.reset_n(reset_n),
		.inst(inst),
		.ctrl(ctrl),
		.num_inst(num_inst),
		.is_halted(is_halted)
	);

	// Branch outcome is resolved inside the datapath
	datapath datapath_inst (
		.clk(clk),
		.reset_n(reset_n),
		.ctrl(ctrl),
		.data(data),
		.address(address),
		.inst(inst),
		.zero(),
		.output_port(output_port)
	);

endmodule

/* bench/cpu_asserts.sv */
`timescale 1ns/1ps

module cpu_asserts (
	input logic clk,
	input logic reset_n,
	input logic read_m,
	input logic write_m,
	input logic is_halted,
	input isa_pkg::word_t num_inst
);

	int fail_count = 0;

	// One bus, one direction at a time
	strobe_exclusive: assert property (@(posedge clk) !(read_m && write_m))
		else begin
			$error("read_m and write_m are high together");
			fail_count++;
		end

	reset_quiet: assert property (@(posedge clk) !reset_n |-> !read_m && !write_m)
		else begin
			$error("memory strobe active while reset_n is low");
			fail_count++;
		end

	halted_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |-> !read_m && !write_m)
		else begin
			$error("memory strobe active while halted");
			fail_count++;
		end

	halted_count_stable: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |=> $stable(num_inst))
		else begin
			$error("num_inst moved while halted");
			fail_count++;
		end

endmodule

bind cpu cpu_asserts cpu_asserts_inst (
	.clk(clk),
	.reset_n(reset_n),
	.read_m(read_m),
	.write_m(write_m),
	.is_halted(is_halted),
	.num_inst(num_inst)
);

/* bench/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

	localparam int mem_words = 256;
	localparam int reset_cycles = 8;
	localparam int quiet_cycles = 20;

	logic clk;
	logic reset_n;
	logic read_m;
	logic write_m;
	isa_pkg::word_t address;
	wire isa_pkg::word_t data;
	isa_pkg::word_t num_inst;
	isa_pkg::word_t output_port;
	logic is_halted;

	isa_pkg::word_t mem [mem_words];
	isa_pkg::word_t exp_addr [$];
	isa_pkg::word_t exp_data [$];
	isa_pkg::word_t exp_out [$];
	isa_pkg::word_t seen_out [$];
	isa_pkg::word_t exp_count;
	isa_pkg::word_t last_out;
	int cycle_count = 0;
	int cycle_limit = 0;
	int late_writes;
	int tests_run;
	int tests_failed;
	int total_checks;
	int total_errors;
	int test_checks;
	int test_errors;

	cpu cpu_inst (
		.clk(clk),
		.reset_n(reset_n),
		.read_m(read_m),
		.write_m(write_m),
		.address(address),
		.data(data),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Memory answers within the cycle
	assign data = read_m ? mem[address[7:0]] : 'z;

	always @(posedge clk) begin
		if (write_m) begin
			mem[address[7:0]] <= data;
		end
		cycle_count <= cycle_count + 1;
	end

	initial begin
		last_out = '0;
	end

	always @(posedge clk) begin
		if (reset_n && output_port !== last_out) begin
			seen_out.push_back(output_port);
			last_out = output_port;
		end
	end

	task automatic check_value(string what, isa_pkg::word_t got, isa_pkg::word_t expected);
		test_checks++;
		assert (got === expected) else begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, expected);
			test_errors++;
		end
	endtask

	task automatic finish_test(string name);
		tests_run++;
		total_checks += test_checks;
		total_errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic load_stimulus();
		int fd;
		int code;
		logic [7:0] tag;
		logic [8*128-1:0] rest;
		isa_pkg::word_t field_1;
		isa_pkg::word_t field_2;
		fd = $fopen("bench/cpu_stim.txt", "r");
		test_checks++;
		assert (fd != 0) else begin
			$display("Cannot open the stimulus file bench/cpu_stim.txt");
			test_errors++;
		end
		if (fd != 0) begin
			code = $fscanf(fd, "%s", tag);
			while (code == 1) begin
				case (tag)
					"#": code = $fgets(rest, fd);
					"P": begin
						code = $fscanf(fd, "%h %h", field_1, field_2);
						mem[field_1[7:0]] = field_2;
					end
					"M": begin
						code = $fscanf(fd, "%h %h", field_1, field_2);
						exp_addr.push_back(field_1);
						exp_data.push_back(field_2);
					end
					"O": begin
						code = $fscanf(fd, "%h", field_1);
						exp_out.push_back(field_1);
					end
					"N": begin
						code = $fscanf(fd, "%h", field_1);
						exp_count = field_1;
					end
					default: begin
						$display("Unknown tag %s in the stimulus file", tag);
						test_errors++;
					end
				endcase
				code = $fscanf(fd, "%s", tag);
			end
			$fclose(fd);
		end
	endtask

	initial begin : watchdog
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
		end
		$display("Timeout: run did not complete within %0d cycles", cycle_limit);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		isa_pkg::word_t addr;
		reset_n = 1'b0;
		late_writes = 0;
		tests_run = 0;
		tests_failed = 0;
		total_checks = 0;
		total_errors = 0;
		test_checks = 0;
		test_errors = 0;
		exp_count = '0;
		foreach (mem[i]) begin
			mem[i] = '0;
		end
		load_stimulus();
		finish_test("stimulus_load");
		cycle_limit = 5 * int'(exp_count) + reset_cycles + 50;

		repeat (reset_cycles) @(posedge clk);
		reset_n <= 1'b1;

		// Sampled on edges, so values seen here are settled
		do begin
			@(posedge clk);
		end while (is_halted !== 1'b1);
		check_value("num_inst at halt", num_inst, exp_count);
		finish_test("halt_count");

		repeat (quiet_cycles) begin
			@(posedge clk);
			if (write_m === 1'b1) begin
				late_writes++;
			end
		end
		test_checks++;
		assert (late_writes == 0) else begin
			$display("Memory was written %0d times after the core halted", late_writes);
			test_errors++;
		end
		finish_test("halt_quiet_bus");

		@(negedge clk);
		foreach (exp_addr[i]) begin
			addr = exp_addr[i];
			check_value($sformatf("mem[%h]", addr[7:0]), mem[addr[7:0]], exp_data[i]);
		end
		finish_test("memory_results");

		test_checks++;
		assert (seen_out.size() == exp_out.size()) else begin
			$display("Output port changed %0d times, but %0d changes were expected",
				seen_out.size(), exp_out.size());
			test_errors++;
		end
		foreach (exp_out[i]) begin
			if (i < seen_out.size()) begin
				check_value($sformatf("output change %0d", i), seen_out[i], exp_out[i]);
			end
		end
		finish_test("output_port");

		test_checks++;
		assert (cpu_inst.cpu_asserts_inst.fail_count == 0) else begin
			$display("Bound bus assertions failed %0d times",
				cpu_inst.cpu_asserts_inst.fail_count);
			test_errors++;
		end
		finish_test("bus_protocol");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* bench/cpu_stim.txt */
# P addr word = memory image, M addr value = expected final memory word
# O value = next expected output_port value, N count = instructions retired at halt
P 00 4137
P 01 43FD
P 02 F780
P 03 8260
P 04 F781
P 05 8261
P 06 F782
P 07 8262
P 08 F783
P 09 8263
P 0A 63A5
P 0B 4F7F
P 0C 8364
P 0D 7170
P 0E 7371
P 0F F780
P 10 8265
P 11 4501
P 12 8166
P 13 F41C
P 14 1701
P 15 4211
P 16 8267
P 17 0701
P 18 8268
P 19 4222
P 1A 8269
P 1B 4144
P 1C 4344
P 1D 1701
P 1E 816A
P 1F 4233
P 20 826B
P 21 0701
P 22 4255
P 23 826C
P 24 F81C
P 25 9027
P 26 826D
P 27 A030
P 28 826E
P 29 F41C
P 2A F01D
P 30 4F01
P 31 FC1C
P 32 836F
P 33 F819
P 70 1234
P 71 0F0F
M 60 0034
M 61 003A
M 62 0035
M 63 FFFF
M 64 A57F
M 65 2143
M 66 1235
M 67 0011
M 68 0000
M 69 0022
M 6A 0000
M 6B 0033
M 6C 0055
M 6D 0000
M 6E 0028
M 6F 0045
M 70 1234
M 71 0F0F
O 1235
O 0055
O 0045
O 0044
N 002B

/* list.f */
design/isa_pkg.sv
design/ctrl_pkg.sv
design/alu.sv
design/register_file.sv
design/datapath.sv
design/control_fsm.sv
design/cpu.sv
bench/cpu_asserts.sv
bench/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu16

sources:
  - design/isa_pkg.sv
  - design/ctrl_pkg.sv
  - design/alu.sv
  - design/register_file.sv
  - design/datapath.sv
  - design/control_fsm.sv
  - design/cpu.sv
  - target: test
    files:
      - bench/cpu_asserts.sv
      - bench/cpu_tb.sv
